// File: common/lua_cpu_pkg.sv
package lua_cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] ttag_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] opcode_t;

	localparam int num_regs = 32;

	localparam ttag_t t_nil = 5'd0;
	localparam ttag_t t_integer = 5'd1;

	localparam opcode_t op_move = 6'd0;

	typedef enum logic [1:0] {
		cmd_run = 2'd0,
		cmd_load_reg = 2'd1,
		cmd_load_type = 2'd2,
		cmd_load_base = 2'd3
	} cmd_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_done = 2'd1,
		st_not_impl = 2'd3
	} status_t;

	typedef enum logic [1:0] {
		wsrc_instr,
		wsrc_dump,
		wsrc_external
	} wsrc_t;

	localparam word_t saved_pc_offset = 32'd20; // savedpc inside the call record
	localparam int tvalue_shift = 3; // 8-byte register slot
	localparam word_t type_field_offset = 32'd4;

endpackage

// File: verilog/control_sequencer.sv
`timescale 1ns/1ps

module control_sequencer import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input cmd_t n,
	input logic pc_done,
	input logic ir_done,
	input logic dump_done,
	input logic global_dirty,
	input status_t instr_status,

	output logic fetch_pc,
	output logic store_pc,
	output logic fetch_instr,
	output logic incr_pc,
	output logic run_instr,
	output logic store_regs,
	output logic ext_write_data,
	output logic ext_write_type,
	output logic write_base,
	output logic clear_dirty,
	output logic clear_valid,
	output wsrc_t wsrc,
	output logic done
);

	typedef enum logic [3:0] {
		s_idle,
		s_fetch_pc,
		s_fetch_instr,
		s_exec,
		s_store_pc,
		s_store_regs,
		s_load_reg,
		s_load_type,
		s_load_base,
		s_finish
	} state_t;

	state_t state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						case (n)
							cmd_run: state <= s_fetch_pc;
							cmd_load_reg: state <= s_load_reg;
							cmd_load_type: state <= s_load_type;
							cmd_load_base: state <= s_load_base;
						endcase
					end
				end
				s_fetch_pc: if (pc_done) state <= s_fetch_instr;
				s_fetch_instr: if (ir_done) state <= s_exec;
				s_exec: begin
					case (instr_status)
						st_done: state <= s_fetch_instr;
						st_not_impl: state <= s_store_pc;
						default: state <= s_exec; // status not back yet
					endcase
				end
				s_store_pc: begin
					if (pc_done)
						state <= global_dirty ? s_store_regs : s_finish;
				end
				s_store_regs: if (dump_done) state <= s_finish;
				s_load_reg, s_load_type, s_load_base: state <= s_finish;
				default: state <= s_idle;
			endcase
		end
	end

	always_comb begin
		fetch_pc = state == s_fetch_pc;
		store_pc = state == s_store_pc;
		fetch_instr = state == s_fetch_instr;
		incr_pc = fetch_instr && ir_done; // step past the fetched word
		run_instr = state == s_exec;
		store_regs = state == s_store_regs;
		ext_write_data = state == s_load_reg;
		ext_write_type = state == s_load_type;
		write_base = state == s_load_base;
		clear_dirty = state == s_finish || write_base;
		clear_valid = write_base;
		done = state == s_finish;
		case (state)
			s_store_regs: wsrc = wsrc_dump;
			s_load_reg, s_load_type: wsrc = wsrc_external;
			default: wsrc = wsrc_instr;
		endcase
	end

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input word_t ci,
	input logic fetch_pc,
	input logic store_pc,
	input logic fetch_instr,
	input logic incr_pc,
	input word_t mem_readdata,
	input logic mem_waitrequest,

	output word_t mem_address,
	output word_t mem_writedata,
	output logic mem_read,
	output logic mem_write,
	output logic pc_done,
	output logic ir_done,
	output word_t instruction,
	output opcode_t opcode,
	output reg_idx_t field_a,
	output reg_idx_t field_b
);

	word_t pc;
	word_t saved_pc_addr;
	logic pc_rd, pc_wr, ir_rd;

	always_comb begin
		saved_pc_addr = ci + saved_pc_offset;
		pc_rd = fetch_pc && !pc_done;
		pc_wr = store_pc && !pc_done;
		ir_rd = fetch_instr && !ir_done;

		mem_address = '0;
		mem_writedata = '0;
		if (pc_rd || pc_wr)
			mem_address = saved_pc_addr;
		else if (ir_rd)
			mem_address = pc;
		if (pc_wr)
			mem_writedata = pc;
		mem_read = pc_rd || ir_rd;
		mem_write = pc_wr;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			pc_done <= 1'b0;
		end else begin
			pc_done <= (pc_rd || pc_wr) && !mem_waitrequest;
			if (pc_rd && !mem_waitrequest)
				pc <= mem_readdata;
			else if (incr_pc)
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instruction <= '0;
			ir_done <= 1'b0;
		end else begin
			ir_done <= ir_rd && !mem_waitrequest;
			if (ir_rd && !mem_waitrequest)
				instruction <= mem_readdata;
		end
	end

	// A is 13..6 and B is 31..23, low bits index the registers
	assign opcode = instruction[5:0];
	assign field_a = instruction[10:6];
	assign field_b = instruction[27:23];

endmodule

// File: verilog/instr_exec.sv
`timescale 1ns/1ps

module instr_exec import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run_instr,
	input opcode_t opcode,
	input word_t data_b,
	input ttag_t type_b,

	output word_t write_data,
	output ttag_t write_type,
	output logic write_en,
	output status_t instr_status
);

	logic first_cycle;

	assign first_cycle = run_instr && instr_status == st_idle;

	// move copies R[B] with its tag into R[A]
	assign write_data = data_b;
	assign write_type = type_b;
	assign write_en = first_cycle && opcode == op_move;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			instr_status <= st_idle;
		else if (first_cycle)
			instr_status <= (opcode == op_move) ? st_done : st_not_impl;
		else
			instr_status <= st_idle; // one-cycle status pulse
	end

endmodule

// File: regfile/lua_register_file.sv
`timescale 1ns/1ps

module lua_register_file import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input wsrc_t wsrc,
	input reg_idx_t field_a,
	input reg_idx_t field_b,
	input reg_idx_t dump_idx,
	input word_t dataa,
	input word_t datab,
	input word_t exec_data,
	input ttag_t exec_type,
	input logic exec_en,
	input logic ext_write_data,
	input logic ext_write_type,
	input logic write_base,
	input logic clear_dirty,
	input logic clear_valid,

	output word_t data_a,
	output ttag_t type_a,
	output logic dirty_a,
	output logic valid_a,
	output word_t data_b,
	output ttag_t type_b,
	output logic global_dirty,
	output word_t base
);

	word_t regs [num_regs];
	ttag_t ttags [num_regs];
	logic [num_regs-1:0] dirty;
	logic [num_regs-1:0] valid;

	word_t ext_idx;
	logic ext_ok;
	reg_idx_t idx_a;

	always_comb begin
		ext_idx = (dataa - base) >> tvalue_shift;
		ext_ok = ext_idx < num_regs; // slot below base wraps high too
		case (wsrc)
			wsrc_dump: idx_a = dump_idx;
			wsrc_external: idx_a = ext_idx[4:0];
			default: idx_a = field_a;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
				ttags[i] <= t_nil;
			end
			dirty <= '0;
			valid <= '0;
			global_dirty <= 1'b0;
			base <= '0;
		end else begin
			if (write_base)
				base <= dataa;
			if (clear_dirty) begin
				dirty <= '0;
				global_dirty <= 1'b0;
			end
			if (clear_valid)
				valid <= '0;
			if (exec_en) begin
				regs[idx_a] <= exec_data;
				ttags[idx_a] <= exec_type;
				dirty[idx_a] <= 1'b1;
				valid[idx_a] <= 1'b1;
				global_dirty <= 1'b1;
			end
			if (ext_write_data && ext_ok) begin
				regs[idx_a] <= datab;
				valid[idx_a] <= 1'b1;
			end
			if (ext_write_type && ext_ok) begin
				ttags[idx_a] <= datab[4:0];
				valid[idx_a] <= 1'b1;
			end
		end
	end

	assign data_a = regs[idx_a];
	assign type_a = ttags[idx_a];
	assign dirty_a = dirty[idx_a];
	assign valid_a = valid[idx_a];
	assign data_b = regs[field_b];
	assign type_b = ttags[field_b];

endmodule

// File: regfile/register_dumper.sv
`timescale 1ns/1ps

module register_dumper import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic store_regs,
	input word_t base,
	input word_t data_a,
	input ttag_t type_a,
	input logic dirty_a,
	input logic valid_a,
	input logic mem_waitrequest,

	output reg_idx_t dump_idx,
	output word_t mem_address,
	output word_t mem_writedata,
	output logic mem_write,
	output logic dump_done
);

	typedef enum logic [1:0] {
		d_idle,
		d_value,
		d_type,
		d_done
	} phase_t;

	phase_t phase;
	reg_idx_t cur;
	logic do_write;
	logic last;
	word_t slot_addr;

	always_comb begin
		do_write = dirty_a && valid_a;
		last = cur == reg_idx_t'(num_regs - 1);
		slot_addr = base + (word_t'(cur) << tvalue_shift);
		dump_idx = cur;
		dump_done = phase == d_done;

		mem_address = '0;
		mem_writedata = '0;
		mem_write = 1'b0;
		if (phase == d_value && do_write) begin
			mem_address = slot_addr;
			mem_writedata = data_a;
			mem_write = 1'b1;
		end else if (phase == d_type && do_write) begin
			mem_address = slot_addr + type_field_offset;
			mem_writedata = {27'd0, type_a};
			mem_write = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= d_idle;
			cur <= '0;
		end else begin
			case (phase)
				d_idle: begin
					if (store_regs) begin
						cur <= '0;
						phase <= d_value;
					end
				end
				d_value: begin
					if (do_write) begin
						if (!mem_waitrequest)
							phase <= d_type;
					end else if (last) begin
						phase <= d_done;
					end else begin
						cur <= cur + 5'd1; // clean register, one cycle
					end
				end
				d_type: begin
					if (!mem_waitrequest) begin
						cur <= cur + 5'd1;
						phase <= last ? d_done : d_value;
					end
				end
				default: phase <= d_idle;
			endcase
		end
	end

endmodule

// File: verilog/lua_cpu.sv
`timescale 1ns/1ps

module lua_cpu import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,

	input logic start,
	input cmd_t n,
	input word_t dataa,
	input word_t datab,
	output logic done,
	output word_t result,

	output word_t mem_address,
	output word_t mem_writedata,
	output logic mem_read,
	output logic mem_write,
	input word_t mem_readdata,
	input logic mem_waitrequest
);

	logic fetch_pc, store_pc, fetch_instr, incr_pc;
	logic run_instr, store_regs;
	logic ext_write_data, ext_write_type, write_base;
	logic clear_dirty, clear_valid;
	wsrc_t wsrc;
	logic pc_done, ir_done, dump_done, global_dirty;
	status_t instr_status;

	opcode_t opcode;
	reg_idx_t field_a, field_b, dump_idx;

	word_t exec_data;
	ttag_t exec_type;
	logic exec_en;

	word_t data_a, data_b, base;
	ttag_t type_a, type_b;
	logic dirty_a, valid_a;

	word_t fetch_address, fetch_writedata;
	logic fetch_read, fetch_write;
	word_t dump_address, dump_writedata;
	logic dump_write;

	control_sequencer u_seq (.*);

	fetch_unit u_fetch (
		.*,
		.ci(datab), // call record address during run
		.instruction(result),
		.mem_address(fetch_address),
		.mem_writedata(fetch_writedata),
		.mem_read(fetch_read),
		.mem_write(fetch_write)
	);

	instr_exec u_exec (
		.*,
		.write_data(exec_data),
		.write_type(exec_type),
		.write_en(exec_en)
	);

	lua_register_file u_regs (.*);

	register_dumper u_dump (
		.*,
		.mem_address(dump_address),
		.mem_writedata(dump_writedata),
		.mem_write(dump_write)
	);

	// idle masters drive zeros
	assign mem_address = fetch_address | dump_address;
	assign mem_writedata = fetch_writedata | dump_writedata;
	assign mem_read = fetch_read;
	assign mem_write = fetch_write | dump_write;

endmodule

// File: sim/lua_cpu_properties.sv
`timescale 1ns/1ps

module lua_cpu_properties import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input word_t mem_address,
	input word_t mem_writedata,
	input logic mem_read,
	input logic mem_write,
	input logic mem_waitrequest,
	input logic done
);

	a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high in the same cycle");

	// a stalled request keeps address, data and direction
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) && mem_waitrequest |=>
		$stable(mem_address) && $stable(mem_writedata) && $stable(mem_read) && $stable(mem_write))
		else $error("bus request changed while waitrequest was high");

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for two cycles");

endmodule

// File: sim/lua_cpu_checker.sv
`timescale 1ns/1ps

module lua_cpu_checker import lua_cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input cmd_t n,
	input word_t dataa,
	input word_t datab,
	input logic done,
	input word_t result,
	input word_t mem_address,
	input word_t mem_writedata,
	input logic mem_read,
	input logic mem_write,
	input word_t mem_readdata,
	input logic mem_waitrequest,
	output int errors
);

	word_t regs [num_regs];
	ttag_t tags [num_regs];
	logic [num_regs-1:0] dirty;
	logic [num_regs-1:0] valid;
	word_t base;

	word_t exp_addr [$];
	word_t exp_data [$];

	logic busy, fetching, pc_read;
	cmd_t cur_cmd;
	word_t ci, exp_pc, stop_instr;
	int cycle, start_cycle;
	logic done_q, prev_rd, prev_wr, prev_wait;
	word_t prev_addr, prev_wdata;

	task automatic log_error(input string what);
		$display("ERROR: %s", what);
		errors++;
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic host_write(input cmd_t cmd, input word_t addr, input word_t value);
		word_t idx;
		idx = (addr - base) >> tvalue_shift;
		if (idx < num_regs) begin // slots past the frame are dropped
			if (cmd == cmd_load_reg)
				regs[idx[4:0]] = value;
			else
				tags[idx[4:0]] = value[4:0];
			valid[idx[4:0]] = 1'b1;
		end
	endtask

	task automatic do_move(input word_t instr);
		reg_idx_t a;
		reg_idx_t b;
		a = instr[10:6]; // low bits of A
		b = instr[27:23]; // low bits of B
		regs[a] = regs[b];
		tags[a] = tags[b];
		dirty[a] = 1'b1;
		valid[a] = 1'b1;
	endtask

	task automatic queue_stores(input word_t pc_value);
		exp_addr.push_back(ci + saved_pc_offset);
		exp_data.push_back(pc_value);
		for (int i = 0; i < num_regs; i++) begin
			if (dirty[i] && valid[i]) begin
				exp_addr.push_back(base + 32'(i) * 8);
				exp_data.push_back(regs[i]);
				exp_addr.push_back(base + 32'(i) * 8 + type_field_offset);
				exp_data.push_back({27'd0, tags[i]});
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] = '0;
				tags[i] = t_nil;
			end
			dirty = '0;
			valid = '0;
			base = '0;
			exp_addr.delete();
			exp_data.delete();
			busy = 1'b0;
			fetching = 1'b0;
			pc_read = 1'b0;
			cur_cmd = cmd_run;
			ci = '0;
			exp_pc = '0;
			stop_instr = '0;
			cycle = 0;
			start_cycle = 0;
			done_q = 1'b0;
			prev_rd = 1'b0;
			prev_wr = 1'b0;
			prev_wait = 1'b0;
			prev_addr = '0;
			prev_wdata = '0;
			errors = 0;
		end else begin
			cycle++;
			if (mem_read && mem_write)
				log_error("mem_read and mem_write high in the same cycle");
			if (prev_wait && (prev_rd || prev_wr) && (mem_read != prev_rd ||
					mem_write != prev_wr || mem_address != prev_addr ||
					mem_writedata != prev_wdata))
				log_error("bus request changed while waitrequest was high");
			if (done && done_q)
				log_error("done stayed high for two cycles");

			if (mem_read && !mem_waitrequest) begin
				if (!fetching) begin
					log_error("bus read outside a run");
				end else if (!pc_read) begin
					check_word("saved pc address", ci + saved_pc_offset, mem_address);
					exp_pc = mem_readdata;
					pc_read = 1'b1;
				end else begin
					check_word("fetch address", exp_pc, mem_address);
					exp_pc = exp_pc + 32'd4;
					if (mem_readdata[5:0] == op_move) begin
						do_move(mem_readdata);
					end else begin
						stop_instr = mem_readdata;
						fetching = 1'b0;
						queue_stores(exp_pc); // pc already past the stopping word
					end
				end
			end

			if (mem_write && !mem_waitrequest) begin
				if (exp_addr.size() == 0) begin
					log_error($sformatf("unexpected bus write to %h", mem_address));
				end else begin
					check_word("bus write address", exp_addr.pop_front(), mem_address);
					check_word("bus write data", exp_data.pop_front(), mem_writedata);
				end
			end

			if (done) begin
				if (!busy) begin
					log_error("done without a command");
				end else if (cur_cmd != cmd_run) begin
					check_word("load done latency", word_t'(start_cycle + 2), word_t'(cycle));
				end else begin
					check_word("run result", stop_instr, result);
					if (fetching)
						log_error("run ended before an unimplemented instruction");
					if (exp_addr.size() != 0)
						log_error("run ended with register stores missing");
				end
				busy = 1'b0;
				fetching = 1'b0;
				dirty = '0; // every command ends through finish
			end

			if (start && !busy) begin
				busy = 1'b1;
				cur_cmd = n;
				start_cycle = cycle;
				ci = datab;
				case (n)
					cmd_run: begin
						fetching = 1'b1;
						pc_read = 1'b0;
					end
					cmd_load_base: begin
						base = dataa;
						dirty = '0;
						valid = '0;
					end
					default: host_write(n, dataa, datab);
				endcase
			end

			done_q = done;
			prev_rd = mem_read;
			prev_wr = mem_write;
			prev_wait = mem_waitrequest;
			prev_addr = mem_address;
			prev_wdata = mem_writedata;
		end
	end

endmodule

// File: sim/lua_cpu_tb.sv
`timescale 1ns/1ps

module lua_cpu_tb import lua_cpu_pkg::*; ();

	localparam word_t call_rec = 32'h0000_0400;
	localparam word_t regs_base = 32'h0000_0800;
	localparam word_t prog_moves = 32'h0000_0100;
	localparam word_t prog_stop = 32'h0000_0200;
	localparam word_t prog_low = 32'h0000_0300;
	localparam int num_loads = 48;
	localparam int num_moves = 12;
	localparam int num_cmds = 2 * (num_loads + 7);

	logic clk = 1'b0;
	logic rst;
	logic start;
	cmd_t n;
	word_t dataa, datab;
	logic done;
	word_t result;
	word_t mem_address, mem_writedata, mem_readdata;
	logic mem_read, mem_write;
	logic mem_waitrequest = 1'b0;

	word_t mem [1024];
	logic pre_we;
	word_t pre_addr, pre_data;
	logic wait_on;
	integer seed;
	integer wait_seed;
	int errors;
	int cmd_count;

	lua_cpu DUT (.*);

	lua_cpu_checker u_checker (.*);

	bind lua_cpu lua_cpu_properties u_props (
		.clk(clk),
		.rst(rst),
		.mem_address(mem_address),
		.mem_writedata(mem_writedata),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_waitrequest(mem_waitrequest),
		.done(done)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		int r;
		r = $random(wait_seed);
		mem_waitrequest <= wait_on && r[0];
	end

	assign mem_readdata = mem[mem_address[11:2]];

	always @(posedge clk) begin
		if (mem_write && !mem_waitrequest)
			mem[mem_address[11:2]] <= mem_writedata;
		if (pre_we)
			mem[pre_addr[11:2]] <= pre_data; // program and call record setup
	end

	function automatic word_t make_instr(input opcode_t op, input reg_idx_t a,
			input reg_idx_t b, input word_t junk);
		word_t w;
		w = junk; // noise in the unused field bits
		w[5:0] = op;
		w[10:6] = a;
		w[27:23] = b;
		return w;
	endfunction

	task automatic mem_put(input word_t addr, input word_t data);
		pre_we <= 1'b1;
		pre_addr <= addr;
		pre_data <= data;
		@(posedge clk);
		pre_we <= 1'b0;
	endtask

	task automatic host_cmd(input cmd_t cmd, input word_t a, input word_t b);
		start <= 1'b1;
		n <= cmd;
		dataa <= a;
		datab <= b;
		cmd_count++;
		@(posedge clk);
		start <= 1'b0;
		do
			@(posedge clk);
		while (!done);
	endtask

	task automatic run_program(input word_t prog, input int moves, input logic from_low);
		int i;
		int r;
		opcode_t stop_op;
		mem_put(call_rec + saved_pc_offset, prog);
		for (i = 0; i < moves; i++) begin
			r = $random(seed);
			mem_put(prog + 4 * i, make_instr(op_move, r[4:0], from_low ? 5'd0 : r[9:5], r));
		end
		r = $random(seed);
		stop_op = (r[5:0] == op_move) ? 6'd1 : r[5:0];
		mem_put(prog + 4 * moves, make_instr(stop_op, r[10:6], r[27:23], r));
		host_cmd(cmd_run, 32'd0, call_rec);
	endtask

	task automatic run_pass(input logic with_wait);
		int i;
		int r;
		word_t slot;
		seed = 88203; // same stimulus in both passes
		wait_on <= with_wait;
		host_cmd(cmd_load_base, regs_base, 32'd0);
		for (i = 0; i < num_loads; i++) begin
			r = $random(seed);
			slot = regs_base + {24'd0, r[4:0], 3'd0};
			if (r[5])
				host_cmd(cmd_load_type, slot, $random(seed));
			else
				host_cmd(cmd_load_reg, slot, $random(seed));
		end
		run_program(prog_moves, num_moves, 1'b0);
		run_program(prog_stop, 0, 1'b0); // stops on its first word
		host_cmd(cmd_load_reg, regs_base + 32'd256, $random(seed)); // index 32, out of range
		host_cmd(cmd_load_type, regs_base + 32'd512, $random(seed));
		host_cmd(cmd_load_reg, regs_base - 32'd8, $random(seed)); // below base
		run_program(prog_low, 1, 1'b1);
	endtask

	initial begin
		seed = 88203;
		wait_seed = 88203;
		rst = 1'b1;
		start = 1'b0;
		n = cmd_run;
		dataa = '0;
		datab = '0;
		wait_on = 1'b0;
		pre_we = 1'b0;
		pre_addr = '0;
		pre_data = '0;
		cmd_count = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		run_pass(1'b0);
		run_pass(1'b1);
		repeat (2) @(posedge clk);
		$display("commands: %0d  errors: %0d", cmd_count, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (num_cmds * 400) @(posedge clk);
		$display("ERROR: timeout, commands did not finish within %0d cycles", num_cmds * 400);
		$display("Test failed");
		$finish;
	end

endmodule

// File: lua_cpu.f
common/lua_cpu_pkg.sv
verilog/control_sequencer.sv
verilog/fetch_unit.sv
verilog/instr_exec.sv
regfile/lua_register_file.sv
regfile/register_dumper.sv
verilog/lua_cpu.sv
sim/lua_cpu_properties.sv
sim/lua_cpu_checker.sv
sim/lua_cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lua_cpu_tb -f lua_cpu.f \
	--Mdir obj_dir -o lua_cpu_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/lua_cpu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "^Test completed successfully$" sim.log && echo "simulation passed" && exit 0 || \
	{ echo "simulation did not pass"; exit 1; }
